// ==== build.f ====
+incdir+verilog
verilog/mandel_pkg.sv
verilog/mandelbrot_alu.sv
verilog/mandel_coord_gen.sv
verilog/mandel_iter_unit.sv
verilog/mandel_top.sv
sim/mandel_clkgen.sv
sim/mandel_assertions.sv
sim/mandel_tb.sv

// ==== Bender.yml ====
package:
  name: mandel_engine

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/mandel_pkg.sv
      - verilog/mandelbrot_alu.sv
      - verilog/mandel_coord_gen.sv
      - verilog/mandel_iter_unit.sv
      - verilog/mandel_top.sv
  - target: simulation
    files:
      - sim/mandel_clkgen.sv
      - sim/mandel_assertions.sv
      - sim/mandel_tb.sv

// ==== sim/mandel_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mandel_defines.svh"

module mandel_tb import mandel_pkg::*; ();
    localparam int FRAC        = `MANDEL_WIDTH - 2;
    localparam int FIX_MAX     = (1 << (`MANDEL_WIDTH - 1)) - 1;
    localparam int FIX_MIN     = -(1 << (`MANDEL_WIDTH - 1));
    localparam int STIM_DLY    = 2;                          // ns after the rising edge
    localparam int PIX_TIMEOUT = `MANDEL_MAX_ITER + 12;      // cycles per pixel

    typedef struct packed {
        coord_t x;
        coord_t y;
        iter_t  iter;
        exit_t  ex;
        logic   last;
    } pix_exp_t;

    logic     clk, rst_n, start;
    fix_t     cr0, ci0, step;
    coord_t   cols, rows;
    logic     pix_valid, frame_done, busy;
    coord_t   pix_x, pix_y;
    iter_t    pix_iter;
    exit_t    pix_exit;
    pix_exp_t exp_q[$];            // expected pixels, row-major
    int       pix_seen = 0;
    logic [31:0] rng = 32'h0237806c;

    mandel_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(16)) i_clkgen (.clk(clk), .rst_n(rst_n));

    mandel_top i_mandel_top (
        .clk(clk), .rst_n(rst_n), .start(start),
        .cr0(cr0), .ci0(ci0), .step(step), .cols(cols), .rows(rows),
        .pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y),
        .pix_iter(pix_iter), .pix_exit(pix_exit),
        .frame_done(frame_done), .busy(busy)
    );

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_coord(input coord_t got, input coord_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_iter(input iter_t got, input iter_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_exit(input exit_t got, input exit_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %0t ns: %s is %s, expected %s", $time, what,
                               got.name(), exp.name()));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // keep only the low width bits, as a signed value
    function automatic int wrap_fix(input int v);
        fix_t t;
        t = fix_t'(v);
        return int'(t);
    endfunction

    // one z <- z^2 + c step, floor scaling via arithmetic shift
    function automatic void ref_step(input int cr, input int ci, input int zr, input int zi,
                                     output int zr_n, output int zi_n,
                                     output bit esc, output bit ovf);
        int full_r;
        int full_i;
        full_r = ((zr * zr - zi * zi) >>> FRAC) + cr;
        full_i = ((2 * zr * zi) >>> FRAC) + ci;
        esc  = ((zr * zr + zi * zi) >>> FRAC) > (4 << FRAC);   // judged on incoming z
        ovf  = (full_r < FIX_MIN) || (full_r > FIX_MAX) ||
               (full_i < FIX_MIN) || (full_i > FIX_MAX);
        zr_n = wrap_fix(full_r);
        zi_n = wrap_fix(full_i);
    endfunction

    function automatic void ref_pixel(input int cr, input int ci, output int iter, output exit_t ex);
        int zr;
        int zi;
        int nr;
        int ni;
        bit esc;
        bit ovf;
        zr   = 0;
        zi   = 0;
        iter = `MANDEL_MAX_ITER;
        ex   = EXIT_BOUNDED;
        for (int k = 0; k < `MANDEL_MAX_ITER; k++) begin
            ref_step(cr, ci, zr, zi, nr, ni, esc, ovf);
            if (esc) begin
                iter = k;
                ex   = EXIT_ESCAPED;
                return;
            end else if (ovf) begin
                iter = k + 1;
                ex   = EXIT_OVERFLOW;
                return;
            end
            zr = nr;                                // limit falls out of the loop bound
            zi = ni;
        end
    endfunction

    // expected results of a whole frame
    task automatic queue_frame(input fix_t o_r, input fix_t o_i, input fix_t st,
                               input int nc, input int nr);
        pix_exp_t e;
        int it;
        exit_t ex;
        for (int y = 0; y < nr; y++) begin
            for (int x = 0; x < nc; x++) begin
                ref_pixel(wrap_fix(int'(o_r) + x * int'(st)), wrap_fix(int'(o_i) + y * int'(st)),
                          it, ex);
                e.x    = coord_t'(x);
                e.y    = coord_t'(y);
                e.iter = iter_t'(it);
                e.ex   = ex;
                e.last = (x == nc - 1) && (y == nr - 1);
                exp_q.push_back(e);
            end
        end
    endtask

    // compare each pixel as it leaves the DUT
    always @(negedge clk) begin
        pix_exp_t e;
        if (rst_n) begin
            if (i_mandel_top.i_iter_unit.i_assertions.fail_cnt != 0)
                fail_run("a bound assertion on the iteration unit failed");
            if (pix_valid) begin
                if (exp_q.size() == 0) fail_run("a pixel arrived that no frame expected");
                e = exp_q.pop_front();
                check_coord(pix_x, e.x, "pix_x");
                check_coord(pix_y, e.y, "pix_y");
                check_iter(pix_iter, e.iter, "pix_iter");
                check_exit(pix_exit, e.ex, "pix_exit");
                check_flag(frame_done, e.last, "frame_done");
                pix_seen++;
            end else begin
                check_flag(frame_done, 1'b0, "frame_done without pixel");
            end
        end
    end

    // called at STIM_DLY after an edge, returns once busy has fallen
    task automatic run_frame(input fix_t o_r, input fix_t o_i, input fix_t st,
                             input int nc, input int nr, input bit poke);
        int base;
        int guard;
        int seen0;
        bit poked;
        poked = 1'b0;
        seen0 = pix_seen;
        queue_frame(o_r, o_i, st, nc, nr);
        cr0   = o_r;
        ci0   = o_i;
        step  = st;
        cols  = coord_t'(nc);
        rows  = coord_t'(nr);
        start = 1'b1;
        @(posedge clk);
        #STIM_DLY;
        start = 1'b0;
        check_flag(busy, 1'b1, "busy after start");
        // busy drops the cycle after frame_done, pixels are counted until then
        while (busy) begin
            base  = pix_seen;
            guard = 0;
            while (pix_seen == base) begin
                if (guard == PIX_TIMEOUT) begin
                    if (exp_q.size() == 0)
                        fail_run("busy stayed high after the last pixel");
                    else
                        fail_run("no pixel before timeout");
                end
                @(posedge clk);
                #STIM_DLY;
                start = 1'b0;
                guard++;
            end
            if (poke && !poked && nc * nr > 2 && pix_seen - seen0 == 2) begin
                start = 1'b1;                       // must be dropped while busy
                poked = 1'b1;
            end
        end
        if (pix_seen - seen0 != nc * nr)
            fail_run($sformatf("[ERROR] %0t ns: frame gave %0d pixels, expected %0d",
                               $time, pix_seen - seen0, nc * nr));
    endtask

    initial begin
        int guard;
        start = 1'b0;
        cr0   = '0;
        ci0   = '0;
        step  = '0;
        cols  = coord_t'(1);
        rows  = coord_t'(1);
        guard = 0;
        while (!rst_n) begin
            if (guard == 40) fail_run("reset was never released");
            @(posedge clk);
            guard++;
        end
        #STIM_DLY;
        // idle after reset
        repeat (8) begin
            check_flag(busy, 1'b0, "busy after reset");
            check_flag(pix_valid, 1'b0, "pix_valid after reset");
            check_flag(frame_done, 1'b0, "frame_done after reset");
            @(posedge clk);
            #STIM_DLY;
        end
        // -2.0 - 1.0i, step 0.5, with a stray start in the middle
        run_frame(fix_t'(-128), fix_t'(-64), fix_t'(32), 4, 3, 1'b1);
        // random frames, each one straight after the previous one
        repeat (6) begin
            rng = xorshift32(rng);
            run_frame(fix_t'(rng[7:0]), fix_t'(rng[15:8]), fix_t'(rng[21:16] + 6'd1),
                      int'(rng[26:24]) + 1, int'(rng[30:28]) + 1, rng[31]);
        end
        repeat (10) @(posedge clk);                 // no stray pixels afterwards
        if (i_mandel_top.i_iter_unit.i_assertions.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            fail_run("a bound assertion on the iteration unit failed");
        end
    end

endmodule

`default_nettype wire

// ==== sim/mandel_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

// strobe rules of the iteration unit
module mandel_assertions (
    input logic clk,
    input logic rst_n,
    input logic c_valid,
    input logic take,
    input logic pix_valid,
    input logic frame_done
);
    int unsigned fail_cnt = 0;       // polled by the testbench monitor

    // generator keeps its item on offer until the unit takes it
    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid && !take |=> c_valid)
        else begin
            $error("c_valid dropped before take");
            fail_cnt <= fail_cnt + 1;
        end

    // a result needs at least one evaluation, so never two in a row
    pix_single: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid |=> !pix_valid)
        else begin
            $error("pix_valid high in two consecutive cycles");
            fail_cnt <= fail_cnt + 1;
        end

    done_with_pix: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> pix_valid)
        else begin
            $error("frame_done without pix_valid");
            fail_cnt <= fail_cnt + 1;
        end

endmodule

bind mandel_iter_unit mandel_assertions i_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .c_valid    (c_valid),
    .take       (take),
    .pix_valid  (pix_valid),
    .frame_done (frame_done)
);

`default_nettype wire

// ==== sim/mandel_clkgen.sv ====
`timescale 1ns/1ns
`default_nettype none

// clock and power-on reset for the testbench
module mandel_clkgen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;                 // release clear of the edge
    end

endmodule

`default_nettype wire

// ==== verilog/mandel_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// mandelbrot pixel engine, coordinate generator feeding one iteration unit
module mandel_top import mandel_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  fix_t   cr0,         // top left corner
    input  fix_t   ci0,
    input  fix_t   step,        // same step in both directions
    input  coord_t cols,
    input  coord_t rows,
    output logic   pix_valid,
    output coord_t pix_x,
    output coord_t pix_y,
    output iter_t  pix_iter,
    output exit_t  pix_exit,
    output logic   frame_done,
    output logic   busy
);
    logic   start_ok;           // start that actually opens a frame
    logic   c_valid;
    logic   c_last;
    fix_t   c_r, c_i;
    coord_t c_x, c_y;
    logic   take;

    assign start_ok = start && !busy;   // starts during a frame are dropped

    // frame in progress
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start_ok) begin
            busy <= 1'b1;
        end else if (frame_done) begin
            busy <= 1'b0;
        end
    end

    mandel_coord_gen i_coord_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start_ok),
        .cr0     (cr0),
        .ci0     (ci0),
        .step    (step),
        .cols    (cols),
        .rows    (rows),
        .take    (take),
        .c_valid (c_valid),
        .c_r     (c_r),
        .c_i     (c_i),
        .c_x     (c_x),
        .c_y     (c_y),
        .c_last  (c_last)
    );

    mandel_iter_unit i_iter_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .c_valid    (c_valid),
        .c_last     (c_last),
        .c_r        (c_r),
        .c_i        (c_i),
        .c_x        (c_x),
        .c_y        (c_y),
        .take       (take),
        .pix_valid  (pix_valid),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_iter   (pix_iter),
        .pix_exit   (pix_exit),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

// ==== verilog/mandel_iter_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mandel_defines.svh"

// second stage
// iterates one pixel at a time, one alu step per clock
module mandel_iter_unit import mandel_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   c_valid,
    input  logic   c_last,
    input  fix_t   c_r,
    input  fix_t   c_i,
    input  coord_t c_x,
    input  coord_t c_y,
    output logic   take,
    output logic   pix_valid,
    output coord_t pix_x,
    output coord_t pix_y,
    output iter_t  pix_iter,
    output exit_t  pix_exit,
    output logic   frame_done
);
    typedef enum logic {ST_IDLE, ST_ITER} state_t;

    state_t state;
    fix_t   cr_q, ci_q;            // c of the pixel in work
    fix_t   zr_q, zi_q;
    iter_t  cnt_q;                 // completed steps k
    iter_t  cnt_inc;
    coord_t x_q, y_q;
    logic   last_q;                // this pixel closes the frame
    fix_t   zr_nxt, zi_nxt;
    logic   escape, overflow;
    logic   done;                  // final evaluation this cycle
    iter_t  res_iter;
    exit_t  res_exit;

    mandelbrot_alu i_alu (
        .cr       (cr_q),
        .ci       (ci_q),
        .zr       (zr_q),
        .zi       (zi_q),
        .zr_next  (zr_nxt),
        .zi_next  (zi_nxt),
        .escape   (escape),
        .overflow (overflow)
    );

    assign take    = c_valid && (state == ST_IDLE);
    assign cnt_inc = cnt_q + iter_t'(1);

    // exit priority, escape first then overflow then the limit
    always_comb begin
        done     = 1'b1;
        res_exit = EXIT_ESCAPED;
        res_iter = cnt_q;
        if (escape) begin
            res_exit = EXIT_ESCAPED;
        end else if (overflow) begin
            res_exit = EXIT_OVERFLOW;
            res_iter = cnt_inc;
        end else if (cnt_inc == iter_t'(`MANDEL_MAX_ITER)) begin
            res_exit = EXIT_BOUNDED;
            res_iter = cnt_inc;
        end else begin
            done = 1'b0;           // keep going
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            pix_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            pix_valid  <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                ST_IDLE: if (take) state <= ST_ITER;
                ST_ITER: begin
                    if (done) begin
                        state      <= ST_IDLE;     // ready again with pix_valid
                        pix_valid  <= 1'b1;
                        frame_done <= last_q;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // working registers and result capture
    always_ff @(posedge clk) begin
        if (take) begin
            cr_q   <= c_r;
            ci_q   <= c_i;
            zr_q   <= '0;
            zi_q   <= '0;
            cnt_q  <= '0;
            x_q    <= c_x;
            y_q    <= c_y;
            last_q <= c_last;
        end else if (state == ST_ITER && !done) begin
            zr_q  <= zr_nxt;
            zi_q  <= zi_nxt;
            cnt_q <= cnt_inc;
        end
        if (state == ST_ITER && done) begin
            pix_x    <= x_q;
            pix_y    <= y_q;
            pix_iter <= res_iter;
            pix_exit <= res_exit;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mandel_coord_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

// first stage
// walks the grid row by row and keeps one c ready for the iteration unit
module mandel_coord_gen import mandel_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,       // already filtered against busy at the top
    input  fix_t   cr0,
    input  fix_t   ci0,
    input  fix_t   step,
    input  coord_t cols,
    input  coord_t rows,
    input  logic   take,        // consumer grabbed the current item
    output logic   c_valid,
    output fix_t   c_r,
    output fix_t   c_i,
    output coord_t c_x,
    output coord_t c_y,
    output logic   c_last
);
    logic last_col;
    logic last_row;

    // config is stable for the whole frame so compare against it directly
    assign last_col = (c_x == cols - coord_t'(1));
    assign last_row = (c_y == rows - coord_t'(1));
    assign c_last   = last_col && last_row;

    // valid flag and grid position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_valid <= 1'b0;
            c_x     <= '0;
            c_y     <= '0;
        end else if (!c_valid) begin
            if (start) begin
                c_valid <= 1'b1;           // pixel (0,0) next cycle
                c_x     <= '0;
                c_y     <= '0;
            end
        end else if (take) begin
            if (c_last) begin
                c_valid <= 1'b0;           // frame fully handed over
            end else if (last_col) begin
                c_x <= '0;
                c_y <= c_y + coord_t'(1);
            end else begin
                c_x <= c_x + coord_t'(1);
            end
        end
    end

    // running c accumulators, add instead of multiply
    always_ff @(posedge clk) begin
        if (!c_valid && start) begin
            c_r <= cr0;
            c_i <= ci0;
        end else if (c_valid && take && !c_last) begin
            if (last_col) begin
                c_r <= cr0;                // back to the left edge
                c_i <= c_i + step;         // wraps in the fixed width
            end else begin
                c_r <= c_r + step;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mandelbrot_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mandel_defines.svh"

// one step of z <- z^2 + c, purely combinational
module mandelbrot_alu import mandel_pkg::*; (
    input  fix_t cr,
    input  fix_t ci,
    input  fix_t zr,
    input  fix_t zi,
    output fix_t zr_next,
    output fix_t zi_next,
    output logic escape,
    output logic overflow
);
    localparam int W  = `MANDEL_WIDTH;
    localparam int F  = `MANDEL_FRAC_BITS;
    localparam int XW = W + 3;                       // room for the untruncated results

    // escape threshold 4.0 in the scaled domain
    localparam logic [XW-1:0] ESC_LIMIT = XW'(4) << F;

    logic signed [2*W-1:0] m_rr;                     // zr*zr
    logic signed [2*W-1:0] m_ii;                     // zi*zi
    logic signed [2*W-1:0] m_ri;                     // zr*zi
    logic signed [2*W:0]   diff_sq;                  // zr^2 - zi^2, one guard bit
    logic signed [2*W:0]   twice_ri;                 // 2*zr*zi
    logic        [2*W:0]   sum_sq;                   // zr^2 + zi^2, never negative
    logic signed [XW-1:0]  rr_scaled;
    logic signed [XW-1:0]  ri_scaled;
    logic signed [XW-1:0]  zr_full;
    logic signed [XW-1:0]  zi_full;
    logic                  ovf_r;
    logic                  ovf_i;

    // full precision products
    assign m_rr = zr * zr;
    assign m_ii = zi * zi;
    assign m_ri = zr * zi;

    assign diff_sq  = m_rr - m_ii;
    assign twice_ri = m_ri <<< 1;

    // dropping the low F bits of a two's complement value is a floor
    assign rr_scaled = diff_sq[2*W:F];
    assign ri_scaled = twice_ri[2*W:F];

    assign zr_full = rr_scaled + cr;                 // cr sign extended
    assign zi_full = ri_scaled + ci;

    // truncate back to the working width
    assign zr_next = zr_full[W-1:0];
    assign zi_next = zi_full[W-1:0];

    // result fits only if every bit above the sign equals it
    assign ovf_r    = !((&zr_full[XW-1:W-1]) || !(|zr_full[XW-1:W-1]));
    assign ovf_i    = !((&zi_full[XW-1:W-1]) || !(|zi_full[XW-1:W-1]));
    assign overflow = ovf_r || ovf_i;

    // magnitude check is on the incoming z
    assign sum_sq = {1'b0, m_rr} + {1'b0, m_ii};   // squares are non-negative
    assign escape = (sum_sq[2*W:F] > ESC_LIMIT);

endmodule

`default_nettype wire

// ==== verilog/mandel_pkg.sv ====
`default_nettype none

`include "mandel_defines.svh"

package mandel_pkg;

    // count must be able to hold the limit itself
    localparam int ITER_BITS = $clog2(`MANDEL_MAX_ITER + 1);

    typedef logic signed [`MANDEL_WIDTH-1:0] fix_t;      // c, z and step
    typedef logic [`MANDEL_COORD_BITS-1:0]   coord_t;    // grid index
    typedef logic [ITER_BITS-1:0]            iter_t;     // iteration count

    // why a pixel stopped iterating
    typedef enum logic [1:0] {
        EXIT_ESCAPED  = 2'd0,   // |z|^2 went above 4
        EXIT_OVERFLOW = 2'd1,   // next z left the number range
        EXIT_BOUNDED  = 2'd2    // ran into the limit
    } exit_t;

endpackage

`default_nettype wire

// ==== verilog/mandel_defines.svh ====
`ifndef MANDEL_DEFINES_SVH
`define MANDEL_DEFINES_SVH

// width of every fixed point value
// format is 2.(width-2) so 8 bits give two integer and six fraction bits
`define MANDEL_WIDTH 8

// grid counters for x and y
`define MANDEL_COORD_BITS 6

// iteration limit per pixel
`define MANDEL_MAX_ITER 31

// derived fraction bit count used by the step arithmetic
`define MANDEL_FRAC_BITS (`MANDEL_WIDTH - 2)

`endif
